// ==== design/ff_stuff_settings.svh ====
/* Byte stuffer settings */
`ifndef FF_STUFF_SETTINGS_SVH
`define FF_STUFF_SETTINGS_SVH

// Byte that must be followed by a stuff byte
`define MARKER_BYTE 8'hFF
`define STUFF_BYTE 8'h00

`define WORD_BYTES 4
// Worst case, every lane is a marker
`define STUFF_BYTES (2 * `WORD_BYTES)

`define FIFO_DEPTH 16

`endif

// ==== design/stream_pkg.sv ====
/* Bitstream data types */
`include "ff_stuff_settings.svh"

package stream_pkg;

    // One bitstream byte
    typedef logic [7:0] byte_t;

    // Input and output word, MSB first on the wire
    typedef logic [`WORD_BYTES*8-1:0] word_t;

    // One marker flag per byte lane, bit 3 is the MS lane
    typedef logic [`WORD_BYTES-1:0] lane_flags_t;

    // Stuffed bytes of one word, left aligned
    typedef logic [`STUFF_BYTES*8-1:0] stuffed_t;

endpackage

// ==== design/fill_pkg.sv ====
/* Fill level and count types */
`include "ff_stuff_settings.svh"

package fill_pkg;

    typedef logic [2:0] ff_count_t;    // 0 to 4 markers in a word
    typedef logic [3:0] byte_count_t;  // 4 to 8 stuffed bytes
    typedef logic [3:0] hold_count_t;  // 0 to 11 bytes in the packer

    // FIFO addressing
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(`FIFO_DEPTH):0] fifo_count_t;

endpackage

// ==== design/ff_detect.sv ====
/* Marker byte detect */
`include "ff_stuff_settings.svh"

module ff_detect (
    input  logic                      clk,
    input  logic                      rst,
    input  stream_pkg::word_t         in_word,
    input  logic                      in_valid,
    output stream_pkg::word_t         det_word,
    output stream_pkg::lane_flags_t   det_flags,
    output logic                      det_valid
);
    import stream_pkg::*;

    lane_flags_t flags_c;

    // Compare every lane against the marker
    always_comb begin
        for (int lane = 0; lane < `WORD_BYTES; lane++) begin
            flags_c[lane] = (in_word[lane*8 +: 8] == `MARKER_BYTE);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            det_valid <= 1'b0;
        end else begin
            det_valid <= in_valid;  // Strobe follows the data by one cycle
        end
    end

    // Payload only moves on a valid word
    always_ff @(posedge clk) begin
        if (in_valid) begin
            det_word  <= in_word;
            det_flags <= flags_c;
        end
    end

endmodule

// ==== design/byte_stuffer.sv ====
/* Stuff byte insertion */
`include "ff_stuff_settings.svh"

module byte_stuffer (
    input  logic                      clk,
    input  logic                      rst,
    input  stream_pkg::word_t         det_word,
    input  stream_pkg::lane_flags_t   det_flags,
    input  logic                      det_valid,
    output stream_pkg::stuffed_t      stf_bytes,
    output fill_pkg::byte_count_t     stf_count,
    output logic                      stf_valid
);
    import stream_pkg::*;
    import fill_pkg::*;

    localparam int STUFF_BITS = `STUFF_BYTES * 8;

    stuffed_t    bytes_c;
    byte_count_t pos;       // Next free byte slot, counted from the MSB
    ff_count_t   ff_cnt;
    byte_t       lane_byte;

    // Walk the lanes MS first, each marker gets a stuff byte right behind it
    always_comb begin
        bytes_c   = '0;
        pos       = '0;
        ff_cnt    = '0;
        lane_byte = '0;
        for (int lane = `WORD_BYTES - 1; lane >= 0; lane--) begin
            lane_byte = det_word[lane*8 +: 8];
            bytes_c[STUFF_BITS - 1 - pos*8 -: 8] = lane_byte;
            pos = pos + 1'b1;
            if (det_flags[lane]) begin
                bytes_c[STUFF_BITS - 1 - pos*8 -: 8] = `STUFF_BYTE;
                pos    = pos + 1'b1;
                ff_cnt = ff_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stf_valid <= 1'b0;
        end else begin
            stf_valid <= det_valid;  // FIFO write strobe
        end
    end

    always_ff @(posedge clk) begin
        if (det_valid) begin
            stf_bytes <= bytes_c;
            stf_count <= byte_count_t'(`WORD_BYTES) + byte_count_t'(ff_cnt);
        end
    end

endmodule

// ==== design/stuff_fifo.sv ====
/* Stuffed word FIFO */
`include "ff_stuff_settings.svh"

module stuff_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  stream_pkg::stuffed_t      wr_bytes,
    input  fill_pkg::byte_count_t     wr_count,
    input  logic                      pop,
    output stream_pkg::stuffed_t      head_bytes,
    output fill_pkg::byte_count_t     head_count,
    output logic                      fifo_empty
);
    import stream_pkg::*;
    import fill_pkg::*;

    stuffed_t    mem_bytes [`FIFO_DEPTH];
    byte_count_t mem_count [`FIFO_DEPTH];

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        full;

    assign fifo_empty = (count == '0);
    assign full       = (count == fifo_count_t'(`FIFO_DEPTH));

    // Show-ahead, head is the oldest entry
    assign head_bytes = mem_bytes[rd_ptr];
    assign head_count = mem_count[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_bytes[wr_ptr] <= wr_bytes;
            mem_count[wr_ptr] <= wr_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at the depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Source has no ready, so the average input rate must stay in bounds
    assert property (@(posedge clk) disable iff (rst) wr_en && !pop |-> !full)
        else $error("stuff_fifo overflow");

    // Packer must only pop a visible head
    assert property (@(posedge clk) disable iff (rst) pop |-> !fifo_empty)
        else $error("stuff_fifo underflow");

endmodule

// ==== design/word_packer.sv ====
/* Output word packer */
`include "ff_stuff_settings.svh"

module word_packer (
    input  logic                      clk,
    input  logic                      rst,
    input  stream_pkg::stuffed_t      head_bytes,
    input  fill_pkg::byte_count_t     head_count,
    input  logic                      fifo_empty,
    output logic                      pop,
    output stream_pkg::word_t         out_word,
    output logic                      out_valid
);
    import fill_pkg::*;

    localparam int HOLD_BYTES = `WORD_BYTES - 1 + `STUFF_BYTES;  // 11
    localparam int HOLD_BITS  = HOLD_BYTES * 8;
    localparam int WORD_BITS  = `WORD_BYTES * 8;
    localparam int PAD_BITS   = HOLD_BITS - `STUFF_BYTES * 8;

    logic [HOLD_BITS-1:0] hold_buf;   // Left aligned, oldest byte on top
    logic [HOLD_BITS-1:0] shifted;
    logic [HOLD_BITS-1:0] keep_mask;
    logic [HOLD_BITS-1:0] head_aligned;
    logic [HOLD_BITS-1:0] buf_next;

    hold_count_t hold_cnt;
    hold_count_t rem_cnt;   // Bytes left after this cycle's emission
    hold_count_t next_cnt;
    logic        emit;

    always_comb begin
        emit    = (hold_cnt >= hold_count_t'(`WORD_BYTES));
        rem_cnt = emit ? hold_cnt - hold_count_t'(`WORD_BYTES) : hold_cnt;

        // Take a new entry only while fewer than a word would remain
        pop = !fifo_empty && (rem_cnt < hold_count_t'(`WORD_BYTES));

        shifted      = emit ? (hold_buf << WORD_BITS) : hold_buf;
        keep_mask    = ~({HOLD_BITS{1'b1}} >> (rem_cnt * 8));
        head_aligned = {head_bytes, {PAD_BITS{1'b0}}} >> (rem_cnt * 8);

        buf_next = shifted & keep_mask;  // Stale bytes below the fill level drop out
        next_cnt = rem_cnt;
        if (pop) begin
            buf_next = buf_next | head_aligned;  // Append right after the held bytes
            next_cnt = rem_cnt + hold_count_t'(head_count);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            hold_cnt  <= next_cnt;
            out_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        hold_buf <= buf_next;
        if (emit) begin
            out_word <= hold_buf[HOLD_BITS-1 -: WORD_BITS];  // MS byte first
        end
    end

    // Pop rule keeps the fill level within the buffer
    assert property (@(posedge clk) disable iff (rst) hold_cnt <= hold_count_t'(HOLD_BYTES))
        else $error("word_packer hold count above %0d", HOLD_BYTES);

endmodule

// ==== design/ff_stuffer_top.sv ====
/* JPEG FF byte stuffer */

module ff_stuffer_top (
    input  logic               clk,
    input  logic               rst,
    input  stream_pkg::word_t  in_word,
    input  logic               in_valid,
    output stream_pkg::word_t  out_word,
    output logic               out_valid
);
    import stream_pkg::*;
    import fill_pkg::*;

    word_t       det_word;
    lane_flags_t det_flags;
    logic        det_valid;

    stuffed_t    stf_bytes;
    byte_count_t stf_count;
    logic        stf_valid;

    stuffed_t    head_bytes;
    byte_count_t head_count;
    logic        fifo_empty;
    logic        pop;

    ff_detect u_detect (
        .clk       (clk),
        .rst       (rst),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .det_word  (det_word),
        .det_flags (det_flags),
        .det_valid (det_valid)
    );

    byte_stuffer u_stuffer (
        .clk       (clk),
        .rst       (rst),
        .det_word  (det_word),
        .det_flags (det_flags),
        .det_valid (det_valid),
        .stf_bytes (stf_bytes),
        .stf_count (stf_count),
        .stf_valid (stf_valid)
    );

    // Absorbs words that grew past four bytes
    stuff_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (stf_valid),
        .wr_bytes   (stf_bytes),
        .wr_count   (stf_count),
        .pop        (pop),
        .head_bytes (head_bytes),
        .head_count (head_count),
        .fifo_empty (fifo_empty)
    );

    word_packer u_packer (
        .clk        (clk),
        .rst        (rst),
        .head_bytes (head_bytes),
        .head_count (head_count),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .out_word   (out_word),
        .out_valid  (out_valid)
    );

endmodule

// ==== dv/tb_clock.sv ====
/* Testbench clock and reset */

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 5;  // 10 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // Release just after the edge
    end

endmodule

// ==== dv/tb_ff_stuffer.sv ====
/* Byte stuffer testbench */

module tb_ff_stuffer;
    timeunit 1ns;
    timeprecision 1ps;

    import stream_pkg::*;

    localparam int DRIVE_DELAY = 1;
    localparam int IDLE_CYCLES = 20;
    localparam int RAND_WORDS  = 200;
    // Input words plus idle cycles, random words take about four cycles each
    localparam int TEST_LENGTH = IDLE_CYCLES + 8 + 4 + 4 + 4 * RAND_WORDS;
    localparam int CYCLE_LIMIT = TEST_LENGTH * 20 + 200;

    logic  clk;
    logic  rst;
    word_t in_word;
    logic  in_valid;
    word_t out_word;
    logic  out_valid;

    byte_t       exp_q[$];  // Reference byte stream, oldest first
    int          error_count;
    int          out_words;
    int          cycle_count;
    logic [31:0] rng;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    ff_stuffer_top dut (
        .clk       (clk),
        .rst       (rst),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .out_word  (out_word),
        .out_valid (out_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h at %0t",
                     name, got, exp, $time);
        end
    endtask

    // Marker bytes are followed by a stuff byte in the model
    task automatic push_expected(input word_t w);
        byte_t b;
        for (int lane = 3; lane >= 0; lane--) begin
            b = w[lane*8 +: 8];
            exp_q.push_back(b);
            if (b == 8'hFF) begin
                exp_q.push_back(8'h00);
            end
        end
    endtask

    task automatic drive_word(input word_t w);
        in_word  = w;
        in_valid = 1'b1;
        push_expected(w);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Only whole words can leave, up to three bytes stay held
    task automatic wait_drain();
        while (exp_q.size() >= 4) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();  // Catch stray words
    endtask

    task automatic idle_test();
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            check_value("out_valid", out_valid, 0);
            idle_cycle();
        end
    endtask

    task automatic plain_words_test();
        int start;
        start = out_words;
        for (int i = 0; i < 8; i++) begin
            drive_word(32'h01234567 + i * 32'h11111111);  // No marker bytes
        end
        wait_drain();
        check_value("plain out_words", out_words - start, 8);
    endtask

    task automatic single_marker_test();
        int start;
        start = out_words;
        drive_word(32'hFF112233);
        drive_word(32'h44FF5566);
        drive_word(32'h7788FF99);
        drive_word(32'hAABBCCFF);
        wait_drain();
        check_value("marker out_words", out_words - start, 5);  // 20 bytes
    endtask

    task automatic all_marker_test();
        int start;
        start = out_words;
        repeat (4) drive_word(32'hFFFFFFFF);
        wait_drain();
        check_value("all marker out_words", out_words - start, 8);
    endtask

    task automatic random_words_test();
        int    sent;
        word_t w;
        sent = 0;
        while (sent < RAND_WORDS) begin
            rng = xorshift32(rng);
            if (rng[1:0] == 2'b00) begin
                for (int lane = 0; lane < 4; lane++) begin
                    rng = xorshift32(rng);
                    w[lane*8 +: 8] = (rng[9:8] == 2'b00) ? 8'hFF : rng[7:0];
                end
                drive_word(w);
                sent++;
            end else begin
                idle_cycle();
            end
        end
        wait_drain();
    endtask

    // Output monitor, outputs settle well before the falling edge
    always @(negedge clk) begin : monitor
        word_t exp_word;
        exp_word = '0;
        if (!rst && out_valid) begin
            if (exp_q.size() < 4) begin
                error_count++;
                $display("Output word 0x%08h arrived with only %0d bytes expected at %0t",
                         out_word, exp_q.size(), $time);
            end else begin
                for (int i = 0; i < 4; i++) begin
                    exp_word = {exp_word[23:0], exp_q.pop_front()};
                end
                check_value("out_word", out_word, exp_word);
            end
            out_words++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the output did not drain", cycle_count);
            $display("Errors: %0d, output words: %0d", error_count, out_words);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        in_word     = '0;
        in_valid    = 1'b0;
        error_count = 0;
        out_words   = 0;
        cycle_count = 0;
        rng         = 32'd49;

        wait (rst === 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;

        idle_test();
        plain_words_test();
        single_marker_test();
        all_marker_test();
        random_words_test();

        $display("Errors: %0d, output words: %0d", error_count, out_words);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
design/stream_pkg.sv
design/fill_pkg.sv
design/ff_detect.sv
design/byte_stuffer.sv
design/stuff_fifo.sv
design/word_packer.sv
design/ff_stuffer_top.sv
dv/tb_clock.sv
dv/tb_ff_stuffer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the byte stuffer simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module tb_ff_stuffer -Mdir obj_dir -o sim_ff_stuffer \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_ff_stuffer > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
cat sim.log

grep -q ">>> FAIL" sim.log && echo "Simulation failed" && exit 1
echo "Simulation passed"
